// File: Makefile
SOURCES := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

obj_dir/Vsudoku_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --top-module sudoku_tb -f filelist.f

run: obj_dir/Vsudoku_tb
	./obj_dir/Vsudoku_tb | tee sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@if ! grep -q "test passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: common/buttons_if.sv
`timescale 1ns/100ps

interface buttons_if;

    // Single-cycle pulses, already debounced.
    logic up;
    logic down;
    logic left;
    logic right;
    logic start;
    logic a;
    logic b;

    modport source (output up, down, left, right, start, a, b);

    modport sink (input up, down, left, right, start, a, b);

endinterface

// File: common/game_pkg.sv
package game_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Game flow.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        GAME_IDLE       = 3'b000,
        PICK_DIFFICULTY = 3'b001,
        LOADING         = 3'b010,
        BROWSE_MAP      = 3'b011,
        PICK_NUMBER     = 3'b100,
        WON             = 3'b101,
        LOST            = 3'b110
    } game_state_t;

    typedef enum logic {
        EASY = 1'b0,
        HARD = 1'b1
    } difficulty_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Defeat limits.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int STRIKE_BITS = 2;
    localparam logic [STRIKE_BITS-1:0] STRIKE_LIMIT = 2'd3;

    // Timer counts, defeat at or above.
    localparam int TIMER_BITS = 11;
    localparam logic [TIMER_BITS-1:0] TIME_LIMIT_EASY = 11'd1800;
    localparam logic [TIMER_BITS-1:0] TIME_LIMIT_HARD = 11'd900;

endpackage

// File: common/grid_pkg.sv
package grid_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Grid geometry.
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int GRID_DIM   = 9;
    localparam int CELL_COUNT = GRID_DIM * GRID_DIM;
    localparam int CELL_BITS  = 4;
    localparam int BOARD_BITS = CELL_COUNT * CELL_BITS;

    // Wide enough to address all 81 cells.
    localparam int INDEX_BITS = 7;

    typedef logic [3:0] coord_t;
    typedef logic [CELL_BITS-1:0] digit_t;
    typedef logic [INDEX_BITS-1:0] cell_index_t;

    // Row-major position of a cell in the board and visibility vectors.
    function automatic cell_index_t cell_index(coord_t row, coord_t col);
        return INDEX_BITS'(row * GRID_DIM + col);
    endfunction

endpackage

// File: filelist.f
common/grid_pkg.sv
common/game_pkg.sv
common/buttons_if.sv
hdl/cursor_mover.sv
hdl/outcome_checker.sv
game/board_updater.sv
game/game_fsm.sv
hdl/sudoku_top.sv
verification/sudoku_tb.sv

// File: game/board_updater.sv
`timescale 1ns/100ps

module board_updater
    import grid_pkg::*, game_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    buttons_if.sink                btn,
    input  game_state_t            state,
    input  coord_t                 pos_i,
    input  coord_t                 pos_j,
    input  logic [BOARD_BITS-1:0]  selected_map,
    input  logic [CELL_COUNT-1:0]  selected_visibility,
    output logic [BOARD_BITS-1:0]  board,
    output logic [CELL_COUNT-1:0]  visibilities,
    output digit_t                 selected_number,
    output logic [STRIKE_BITS-1:0] strikes,
    output logic                   error,
    output logic                   cell_visible,
    output logic                   guess_ok,
    output logic                   board_loaded
);

    cell_index_t cell_idx;
    digit_t      cell_value;

    // ~~~~~~~~~~~~~~~~~~~~
    // Cell under the cursor.
    // ~~~~~~~~~~~~~~~~~~~~
    assign cell_idx     = cell_index(pos_i, pos_j);
    assign cell_value   = board[cell_idx * CELL_BITS +: CELL_BITS];
    assign cell_visible = visibilities[cell_idx];
    assign board_loaded = |visibilities;

    assign guess_ok = btn.a && (state == PICK_NUMBER) && (selected_number == cell_value);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board           <= '0;
            visibilities    <= '0;
            selected_number <= 4'd1;
            strikes         <= '0;
            error           <= 1'b0;
        end else begin
            error <= 1'b0;

            case (state)
                LOADING: begin
                    board        <= selected_map;
                    visibilities <= selected_visibility;
                    strikes      <= '0;
                end
                PICK_NUMBER: begin
                    if (btn.up) begin
                        selected_number <= (selected_number == 4'd9) ? 4'd1
                                                                     : selected_number + 4'd1;
                    end else if (btn.down) begin
                        selected_number <= (selected_number == 4'd1) ? 4'd9
                                                                     : selected_number - 4'd1;
                    end

                    if (guess_ok) begin
                        visibilities[cell_idx] <= 1'b1;
                    end else if (btn.a) begin
                        error <= 1'b1;
                        if (strikes != STRIKE_LIMIT) begin
                            strikes <= strikes + 2'd1;
                        end
                    end
                end
                default: begin
                    // Digit starts at 1 on every entry to PICK_NUMBER.
                    selected_number <= 4'd1;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Assertions.
    // ~~~~~~~~~~~~~~~~~~~~
    // At the limit the count holds until the next load.
    strikes_bounded: assert property (
        @(posedge clk) disable iff (reset)
        (strikes == STRIKE_LIMIT) && (state != LOADING) |=> strikes == STRIKE_LIMIT
    );

endmodule

// File: game/game_fsm.sv
`timescale 1ns/100ps

module game_fsm
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    buttons_if.sink     btn,
    input  logic        cell_visible,
    input  logic        guess_ok,
    input  logic        board_loaded,
    input  logic        victory,
    input  logic        defeat,
    output game_state_t state,
    output difficulty_t difficulty,
    output logic        playing
);

    game_state_t next_state;

    // ~~~~~~~~~~~~~~~~~~~~
    // State register.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= GAME_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Difficulty is kept across games until changed again.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            difficulty <= EASY;
        end else if (state == PICK_DIFFICULTY && (btn.up || btn.down)) begin
            difficulty <= (difficulty == EASY) ? HARD : EASY;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Next state.
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        next_state = state;

        case (state)
            GAME_IDLE, WON, LOST: begin
                if (btn.start) begin
                    next_state = PICK_DIFFICULTY;
                end
            end
            PICK_DIFFICULTY: begin
                if (btn.a) begin
                    next_state = LOADING;
                end
            end
            LOADING: begin
                if (board_loaded) begin
                    next_state = BROWSE_MAP;
                end
            end
            BROWSE_MAP: begin
                if (btn.a && !cell_visible) begin
                    next_state = PICK_NUMBER;
                end
            end
            PICK_NUMBER: begin
                if (guess_ok || btn.b) begin
                    next_state = BROWSE_MAP;
                end
            end
            default: begin
                next_state = GAME_IDLE;
            end
        endcase

        // Defeat is checked last so it wins a tie.
        if (victory) begin
            next_state = WON;
        end
        if (defeat) begin
            next_state = LOST;
        end
    end

    assign playing = (state == BROWSE_MAP) || (state == PICK_NUMBER);

    // ~~~~~~~~~~~~~~~~~~~~
    // Assertions.
    // ~~~~~~~~~~~~~~~~~~~~
    state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {GAME_IDLE, PICK_DIFFICULTY, LOADING, BROWSE_MAP,
                      PICK_NUMBER, WON, LOST}
    );

endmodule

// File: hdl/cursor_mover.sv
`timescale 1ns/100ps

module cursor_mover
    import grid_pkg::*, game_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    buttons_if.sink     btn,
    input  game_state_t state,
    output coord_t      pos_i,
    output coord_t      pos_j
);

    localparam coord_t LAST = coord_t'(GRID_DIM - 1);

    // One step along an axis, wrapping at both edges.
    function automatic coord_t step(coord_t pos, logic inc, logic dec);
        if (inc) begin
            return (pos == LAST) ? '0 : pos + 4'd1;
        end
        if (dec) begin
            return (pos == '0) ? LAST : pos - 4'd1;
        end
        return pos;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos_i <= '0;
            pos_j <= '0;
        end else if (state == BROWSE_MAP) begin
            // Row 0 is the top of the grid.
            pos_i <= step(pos_i, btn.down, btn.up);
            pos_j <= step(pos_j, btn.right, btn.left);
        end
    end

    cursor_in_grid: assert property (
        @(posedge clk) disable iff (reset)
        (pos_i < GRID_DIM) && (pos_j < GRID_DIM)
    );

endmodule

// File: hdl/outcome_checker.sv
`timescale 1ns/100ps

module outcome_checker
    import grid_pkg::*, game_pkg::*;
(
    input  logic [CELL_COUNT-1:0]  visibilities,
    input  logic [STRIKE_BITS-1:0] strikes,
    input  logic [TIMER_BITS-1:0]  timer,
    input  difficulty_t            difficulty,
    input  game_state_t            state,
    output logic                   victory,
    output logic                   defeat
);

    logic                  in_play;
    logic [TIMER_BITS-1:0] time_limit;
    logic                  out_of_time;
    logic                  out_of_strikes;

    // Outcomes only count while a puzzle is on the board.
    assign in_play = (state == BROWSE_MAP) || (state == PICK_NUMBER);

    assign time_limit     = (difficulty == HARD) ? TIME_LIMIT_HARD : TIME_LIMIT_EASY;
    assign out_of_time    = timer >= time_limit;
    assign out_of_strikes = strikes >= STRIKE_LIMIT;

    assign victory = in_play && (&visibilities);
    assign defeat  = in_play && (out_of_strikes || out_of_time);

endmodule

// File: hdl/sudoku_top.sv
`timescale 1ns/100ps

module sudoku_top
    import grid_pkg::*, game_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [TIMER_BITS-1:0]  timer,
    input  logic                   up_button,
    input  logic                   down_button,
    input  logic                   left_button,
    input  logic                   right_button,
    input  logic                   start_button,
    input  logic                   a_button,
    input  logic                   b_button,
    input  logic [BOARD_BITS-1:0]  selected_map,
    input  logic [CELL_COUNT-1:0]  selected_visibility,
    output coord_t                 pos_i,
    output coord_t                 pos_j,
    output digit_t                 selected_number,
    output logic [STRIKE_BITS-1:0] strikes,
    output logic                   error,
    output logic [BOARD_BITS-1:0]  board,
    output logic [CELL_COUNT-1:0]  visibilities,
    output game_state_t            state,
    output difficulty_t            difficulty,
    output logic                   playing
);

    logic cell_visible;
    logic guess_ok;
    logic board_loaded;
    logic victory;
    logic defeat;

    // ~~~~~~~~~~~~~~~~~~~~
    // Button bus.
    // ~~~~~~~~~~~~~~~~~~~~
    buttons_if btn_bus ();

    assign btn_bus.up    = up_button;
    assign btn_bus.down  = down_button;
    assign btn_bus.left  = left_button;
    assign btn_bus.right = right_button;
    assign btn_bus.start = start_button;
    assign btn_bus.a     = a_button;
    assign btn_bus.b     = b_button;

    // ~~~~~~~~~~~~~~~~~~~~
    // Blocks.
    // ~~~~~~~~~~~~~~~~~~~~
    game_fsm fsm_i (
        .clk          (clk),
        .reset        (reset),
        .btn          (btn_bus.sink),
        .cell_visible (cell_visible),
        .guess_ok     (guess_ok),
        .board_loaded (board_loaded),
        .victory      (victory),
        .defeat       (defeat),
        .state        (state),
        .difficulty   (difficulty),
        .playing      (playing)
    );

    board_updater board_i (
        .clk                 (clk),
        .reset               (reset),
        .btn                 (btn_bus.sink),
        .state               (state),
        .pos_i               (pos_i),
        .pos_j               (pos_j),
        .selected_map        (selected_map),
        .selected_visibility (selected_visibility),
        .board               (board),
        .visibilities        (visibilities),
        .selected_number     (selected_number),
        .strikes             (strikes),
        .error               (error),
        .cell_visible        (cell_visible),
        .guess_ok            (guess_ok),
        .board_loaded        (board_loaded)
    );

    cursor_mover cursor_i (
        .clk   (clk),
        .reset (reset),
        .btn   (btn_bus.sink),
        .state (state),
        .pos_i (pos_i),
        .pos_j (pos_j)
    );

    outcome_checker outcome_i (
        .visibilities (visibilities),
        .strikes      (strikes),
        .timer        (timer),
        .difficulty   (difficulty),
        .state        (state),
        .victory      (victory),
        .defeat       (defeat)
    );

endmodule

// File: verification/sudoku_tb.sv
`timescale 1ns/100ps

module sudoku_tb
    import grid_pkg::*, game_pkg::*;
();

    localparam logic [2:0] BTN_NONE  = 3'd0;
    localparam logic [2:0] BTN_UP    = 3'd1;
    localparam logic [2:0] BTN_DOWN  = 3'd2;
    localparam logic [2:0] BTN_LEFT  = 3'd3;
    localparam logic [2:0] BTN_RIGHT = 3'd4;
    localparam logic [2:0] BTN_START = 3'd5;
    localparam logic [2:0] BTN_A     = 3'd6;
    localparam logic [2:0] BTN_B     = 3'd7;
    localparam int WAIT_LIMIT = 8;

    // One pulse and the outputs expected after the next edge.
    typedef struct packed {
        logic [2:0]             code;
        logic [TIMER_BITS-1:0]  timer;
        game_state_t            st;
        coord_t                 pi;
        coord_t                 pj;
        digit_t                 num;
        logic [STRIKE_BITS-1:0] strikes;
        logic                   err;
    } step_t;

    logic                   clk;
    logic                   reset;
    logic [TIMER_BITS-1:0]  timer;
    logic                   up_button;
    logic                   down_button;
    logic                   left_button;
    logic                   right_button;
    logic                   start_button;
    logic                   a_button;
    logic                   b_button;
    logic [BOARD_BITS-1:0]  selected_map;
    logic [CELL_COUNT-1:0]  selected_visibility;
    coord_t                 pos_i;
    coord_t                 pos_j;
    digit_t                 selected_number;
    logic [STRIKE_BITS-1:0] strikes;
    logic                   error;
    logic [BOARD_BITS-1:0]  board;
    logic [CELL_COUNT-1:0]  visibilities;
    game_state_t            state;
    difficulty_t            difficulty;
    logic                   playing;

    step_t                  steps[$];
    coord_t                 exp_i;
    coord_t                 exp_j;
    digit_t                 exp_num;
    logic [STRIKE_BITS-1:0] exp_strikes;
    logic [TIMER_BITS-1:0]  timer_val;
    logic [CELL_COUNT-1:0]  revealed;
    int                     errors;
    int                     checks;
    int                     row_count;
    logic                   aborted;

    sudoku_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Shifted-row pattern, a valid solved grid.
    function automatic digit_t solution(input int i, input int j);
        return digit_t'((3 * i + i / 3 + j) % 9 + 1);
    endfunction

    task automatic drive_buttons(input logic [2:0] code);
        up_button    = (code == BTN_UP);
        down_button  = (code == BTN_DOWN);
        left_button  = (code == BTN_LEFT);
        right_button = (code == BTN_RIGHT);
        start_button = (code == BTN_START);
        a_button     = (code == BTN_A);
        b_button     = (code == BTN_B);
    endtask

    task automatic check_value(input string what, input int got, input int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("FAILED at %0t: step %0d, %s is %0d, expected %0d",
                     $time, row_count, what, got, want);
        end
    endtask

    task automatic add_step(input logic [2:0] code, input game_state_t st, input logic err);
        step_t s;
        s = {code, timer_val, st, exp_i, exp_j, exp_num, exp_strikes, err};
        steps.push_back(s);
    endtask

    // Cursor step in BROWSE_MAP, wrapping between 0 and 8.
    task automatic move(input logic [2:0] code);
        case (code)
            BTN_UP:    exp_i = (exp_i == 4'd0) ? 4'd8 : exp_i - 4'd1;
            BTN_DOWN:  exp_i = (exp_i == 4'd8) ? 4'd0 : exp_i + 4'd1;
            BTN_LEFT:  exp_j = (exp_j == 4'd0) ? 4'd8 : exp_j - 4'd1;
            BTN_RIGHT: exp_j = (exp_j == 4'd8) ? 4'd0 : exp_j + 4'd1;
            default: begin
            end
        endcase
        add_step(code, BROWSE_MAP, 1'b0);
    endtask

    // Takes the shorter way round the digit ring.
    task automatic pick_digit(input digit_t target);
        int ahead;
        while (exp_num != target) begin
            ahead = (int'(target) - int'(exp_num) + 9) % 9;
            if (ahead <= 4) begin
                exp_num = (exp_num == 4'd9) ? 4'd1 : exp_num + 4'd1;
                add_step(BTN_UP, PICK_NUMBER, 1'b0);
            end else begin
                exp_num = (exp_num == 4'd1) ? 4'd9 : exp_num - 4'd1;
                add_step(BTN_DOWN, PICK_NUMBER, 1'b0);
            end
        end
    endtask

    task automatic reveal(input coord_t i, input coord_t j);
        while (exp_i != i) begin
            move(BTN_DOWN);
        end
        while (exp_j != j) begin
            move(BTN_RIGHT);
        end
        add_step(BTN_A, PICK_NUMBER, 1'b0);
        pick_digit(solution(int'(i), int'(j)));
        add_step(BTN_A, BROWSE_MAP, 1'b0);
        exp_num = 4'd1;
        revealed[int'(i) * GRID_DIM + int'(j)] = 1'b1;
    endtask

    // Pulse on a falling edge, check on the next one.
    task automatic run_steps();
        step_t s;
        while (steps.size() > 0 && !aborted) begin
            s = steps.pop_front();
            drive_buttons(s.code);
            timer = s.timer;
            @(negedge clk);
            drive_buttons(BTN_NONE);
            check_value("state", int'(state), int'(s.st));
            check_value("pos_i", int'(pos_i), int'(s.pi));
            check_value("pos_j", int'(pos_j), int'(s.pj));
            check_value("selected_number", int'(selected_number), int'(s.num));
            check_value("strikes", int'(strikes), int'(s.strikes));
            check_value("error", int'(error), int'(s.err));
            row_count++;
        end
        steps.delete();
    endtask

    task automatic wait_for_state(input game_state_t st);
        int n;
        n = 0;
        if (!aborted) begin
            while (state != st && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (state != st) begin
                $display("Timed out after %0d cycles waiting for state %0d", n, int'(st));
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] rng;
        rng         = 32'hd37b_2d12;
        errors      = 0;
        checks      = 0;
        row_count   = 0;
        aborted     = 1'b0;
        reset       = 1'b1;
        timer       = '0;
        timer_val   = '0;
        exp_i       = '0;
        exp_j       = '0;
        exp_num     = 4'd1;
        exp_strikes = '0;
        drive_buttons(BTN_NONE);
        for (int k = 0; k < CELL_COUNT; k++) begin
            rng = xorshift(rng);
            selected_visibility[k] = (rng[2:0] != 3'd0);
            selected_map[k*CELL_BITS +: CELL_BITS] = solution(k / GRID_DIM, k % GRID_DIM);
        end
        // Cells (0,1), (4,4) and (8,8) always start hidden.
        selected_visibility[1]  = 1'b0;
        selected_visibility[40] = 1'b0;
        selected_visibility[80] = 1'b0;
        revealed = selected_visibility;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // First game on HARD.
        add_step(BTN_NONE, GAME_IDLE, 1'b0);
        add_step(BTN_UP, GAME_IDLE, 1'b0);
        add_step(BTN_START, PICK_DIFFICULTY, 1'b0);
        add_step(BTN_UP, PICK_DIFFICULTY, 1'b0);
        add_step(BTN_LEFT, PICK_DIFFICULTY, 1'b0);
        add_step(BTN_A, LOADING, 1'b0);
        run_steps();
        wait_for_state(BROWSE_MAP);
        if (!aborted) begin
            check_value("difficulty", int'(difficulty), int'(HARD));
            check_value("playing", int'(playing), 1);
            check_value("board loaded", int'(board == selected_map), 1);
            check_value("visibility loaded", int'(visibilities == selected_visibility), 1);
        end

        move(BTN_UP);
        move(BTN_LEFT);
        move(BTN_DOWN);
        move(BTN_RIGHT);
        move(BTN_RIGHT);
        add_step(BTN_A, PICK_NUMBER, 1'b0);
        add_step(BTN_LEFT, PICK_NUMBER, 1'b0);
        exp_num = 4'd2;
        add_step(BTN_UP, PICK_NUMBER, 1'b0);
        add_step(BTN_B, BROWSE_MAP, 1'b0);
        exp_num = 4'd1;
        reveal(4'd8, 4'd8);
        timer_val = 11'd899;
        add_step(BTN_NONE, BROWSE_MAP, 1'b0);
        timer_val = 11'd900;
        add_step(BTN_NONE, LOST, 1'b0);
        timer_val = '0;
        add_step(BTN_START, PICK_DIFFICULTY, 1'b0);
        add_step(BTN_DOWN, PICK_DIFFICULTY, 1'b0);
        add_step(BTN_A, LOADING, 1'b0);
        run_steps();
        check_value("revealed cells", int'(visibilities == revealed), 1);
        check_value("playing while loading", int'(playing), 0);

        // Second game on EASY ends in strikes.
        wait_for_state(BROWSE_MAP);
        revealed = selected_visibility;
        check_value("difficulty", int'(difficulty), int'(EASY));
        check_value("visibility reloaded", int'(visibilities == revealed), 1);
        timer_val = 11'd900;
        add_step(BTN_NONE, BROWSE_MAP, 1'b0);
        add_step(BTN_NONE, BROWSE_MAP, 1'b0);
        timer_val = '0;
        move(BTN_DOWN);
        move(BTN_RIGHT);
        move(BTN_RIGHT);
        // Cell (0,1) holds 2, so digit 1 is wrong.
        add_step(BTN_A, PICK_NUMBER, 1'b0);
        for (int k = 0; k < 3; k++) begin
            exp_strikes = exp_strikes + 2'd1;
            add_step(BTN_A, PICK_NUMBER, 1'b1);
            if (k == 2) begin
                add_step(BTN_NONE, LOST, 1'b0);
            end else begin
                add_step(BTN_NONE, PICK_NUMBER, 1'b0);
            end
        end
        add_step(BTN_START, PICK_DIFFICULTY, 1'b0);
        add_step(BTN_A, LOADING, 1'b0);
        run_steps();

        // Third game, solved to the end.
        wait_for_state(BROWSE_MAP);
        exp_strikes = '0;
        check_value("strikes cleared", int'(strikes), 0);
        for (int k = 0; k < CELL_COUNT; k++) begin
            if (!selected_visibility[k]) begin
                reveal(coord_t'(k / GRID_DIM), coord_t'(k % GRID_DIM));
            end
        end
        add_step(BTN_NONE, WON, 1'b0);
        run_steps();
        check_value("all cells visible", int'(&visibilities), 1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
